//--- verilog/main_pkg.sv
/* Memory map, I/O offsets and bus timing constants of the main CPU board.
   Region values compare against the top address nibble. */
package main_pkg;

    // Bus widths
    localparam int addr_w     = 16;
    localparam int data_w     = 8;
    localparam int rom_addr_w = 18;
    localparam int ram_addr_w = 13;
    localparam int pos_w      = 9;   // Scroll position

    // Top nibble of the CPU address
    localparam logic [3:0] region_ram  = 4'h0;  // 0 and 1
    localparam logic [3:0] region_scr  = 4'h2;  // 2 and 3
    localparam logic [3:0] region_io   = 4'h4;
    localparam logic [3:0] region_char = 4'h5;
    localparam logic [3:0] region_pal  = 4'h7;

    // I/O write offsets
    localparam logic [2:0] io_bank    = 3'd0;
    localparam logic [2:0] io_ctrl    = 3'd1;
    localparam logic [2:0] io_hpos_lo = 3'd2;
    localparam logic [2:0] io_hpos_hi = 3'd3;
    localparam logic [2:0] io_vpos_lo = 3'd4;
    localparam logic [2:0] io_vpos_hi = 3'd5;
    localparam logic [2:0] io_snd     = 3'd6;

    // Cabinet read offsets
    localparam logic [2:0] cab_sys  = 3'd0;
    localparam logic [2:0] cab_joy1 = 3'd1;
    localparam logic [2:0] cab_joy2 = 3'd2;
    localparam logic [2:0] cab_dipa = 3'd3;
    localparam logic [2:0] cab_dipb = 3'd4;

    localparam logic [data_w-1:0] idle_byte = 8'hff;  // Open bus

    // Bus phases
    localparam logic [1:0] phase_q = 2'd1;
    localparam logic [1:0] phase_e = 2'd3;

    // Mapping PROMs
    localparam int prom_depth = 256;
    localparam int prom_w     = 4;
    localparam int prom_aw    = 8;

    typedef enum logic [1:0] {
        st_run,
        st_mem_wait,
        st_dev_wait
    } wait_state_t;

endpackage

//--- verilog/addr_decode.sv
/* Address decoder and CPU read mux. Selects are combinational levels, low while cpu_vma is low.
   Nibble 4 with address bit 3 clear selects nothing. */
`timescale 1ns/10ps

module addr_decode import main_pkg::*; (
    input  logic [addr_w-1:0] cpu_addr,
    input  logic              cpu_rnw,
    input  logic              cpu_vma,
    input  logic [data_w-1:0] rom_data,
    input  logic [data_w-1:0] ram_data,
    input  logic [data_w-1:0] scr_dout,
    input  logic [data_w-1:0] char_dout,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic [5:0]        joystick1,
    input  logic [5:0]        joystick2,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    output logic              ram_cs,
    output logic              scr_cs,
    output logic              io_cs,
    output logic              rom_cs,
    output logic              char_cs,
    output logic              pal_cs,
    output logic [data_w-1:0] cpu_din
);

    logic [3:0]        nibble;
    logic [data_w-1:0] cabinet;

    assign nibble = cpu_addr[15:12];

    always_comb begin
        ram_cs  = 1'b0;
        scr_cs  = 1'b0;
        io_cs   = 1'b0;
        rom_cs  = 1'b0;
        char_cs = 1'b0;
        pal_cs  = 1'b0;
        if (cpu_vma) begin
            if (nibble[3:1] == region_ram[3:1]) begin
                ram_cs = 1'b1;
            end else if (nibble[3:1] == region_scr[3:1]) begin
                scr_cs = 1'b1;
            end else if (nibble == region_io) begin
                io_cs = cpu_addr[3];
            end else if (cpu_rnw) begin
                rom_cs = 1'b1;       // ROM covers the rest on reads
            end else begin
                // Video memories written behind the ROM space
                char_cs = nibble == region_char;
                pal_cs  = nibble == region_pal;
            end
        end
    end

    always_comb begin
        case (cpu_addr[2:0])
            cab_sys:  cabinet = {coin_input, service, 3'b111, start_button};
            cab_joy1: cabinet = {2'b11, joystick1};
            cab_joy2: cabinet = {2'b11, joystick2};
            cab_dipa: cabinet = dipsw_a;
            cab_dipb: cabinet = dipsw_b;
            default:  cabinet = idle_byte;
        endcase
    end

    assign cpu_din = rom_cs  ? rom_data  :
                     ram_cs  ? ram_data  :
                     scr_cs  ? scr_dout  :
                     char_cs ? char_dout :
                     io_cs   ? cabinet   : idle_byte;

endmodule

//--- verilog/main_io_regs.sv
/* CPU write registers and the vertical-blank interrupt. Everything moves on cen_q only,
   so a stalled bus cycle leaves the registers untouched. */
`timescale 1ns/10ps

module main_io_regs import main_pkg::*; (
    input  logic              clk,
    input  logic              nRESET,
    input  logic              cen_q,
    input  logic              io_cs,
    input  logic              cpu_rnw,
    input  logic [2:0]        cpu_addr,
    input  logic [data_w-1:0] cpu_dout,
    input  logic              lvbl,
    input  logic              dip_pause,
    input  logic              irq_ack,
    output logic [7:0]        bank,
    output logic              flip,
    output logic              sres_b,      // Sound CPU reset, active low
    output logic [pos_w-1:0]  scr_hpos,
    output logic [pos_w-1:0]  scr_vpos,
    output logic [data_w-1:0] snd_latch,
    output logic              irq_n
);

    logic io_wr;
    logic last_lvbl;

    assign io_wr = cen_q && io_cs && !cpu_rnw;

    always_ff @(posedge clk or negedge nRESET) begin
        if (!nRESET) begin
            bank      <= '0;
            flip      <= 1'b0;
            sres_b    <= 1'b1;   // Sound CPU runs out of reset
            scr_hpos  <= '0;
            scr_vpos  <= '0;
            snd_latch <= '0;
        end else if (io_wr) begin
            case (cpu_addr)
                io_bank: bank <= cpu_dout;
                io_ctrl: begin
                    flip   <= cpu_dout[7];
                    sres_b <= cpu_dout[4];
                end
                io_hpos_lo: scr_hpos[7:0] <= cpu_dout;
                io_hpos_hi: scr_hpos[8]   <= cpu_dout[0];
                io_vpos_lo: scr_vpos[7:0] <= cpu_dout;
                io_vpos_hi: scr_vpos[8]   <= cpu_dout[0];
                io_snd:     snd_latch     <= cpu_dout;
                default: ;  // Offset 7 not wired
            endcase
        end
    end

    // Interrupt on the start of vertical blank
    always_ff @(posedge clk or negedge nRESET) begin
        if (!nRESET) begin
            last_lvbl <= 1'b0;
            irq_n     <= 1'b1;
        end else if (cen_q) begin
            last_lvbl <= lvbl;
            if (irq_ack) begin
                irq_n <= 1'b1;
            end else if (last_lvbl && !lvbl && !dip_pause) begin
                irq_n <= 1'b0;
            end
        end
    end

    // A register only moves on the clk after a CPU write to the I/O block
    a_no_stray_write: assert property (
        @(posedge clk) disable iff (!nRESET)
        !io_wr |=> $stable({bank, flip, sres_b, scr_hpos, scr_vpos, snd_latch})
    ) else $error("main_io_regs: register changed without an I/O write");

endmodule

//--- verilog/bank_prom.sv
/* 256x4 mapping PROM held in RAM so it can be loaded at start-up.
   Contents are undefined until loaded, read data lags rd_addr by one clk. */
`timescale 1ns/10ps

module bank_prom import main_pkg::*; (
    input  logic               clk,
    input  logic [prom_aw-1:0] rd_addr,
    input  logic [prom_aw-1:0] wr_addr,
    input  logic [prom_w-1:0]  din,
    input  logic               we,
    output logic [prom_w-1:0]  q
);

    logic [prom_w-1:0] mem [prom_depth];

    // Load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        q <= mem[rd_addr];   // Registered read
    end

endmodule

//--- verilog/cpu_phase_counter.sv
/* Four-phase bus sequencer for the 6809 clock enables. cen_q and cen_e are
   registered, high for the clk in which phase holds their value. */
`timescale 1ns/10ps

module cpu_phase_counter import main_pkg::*; (
    input  logic       clk,
    input  logic       nRESET,
    input  logic       cen8,
    input  logic       hold,
    output logic [1:0] phase,
    output logic       cen_q,
    output logic       cen_e
);

    logic [1:0] phase_next;

    assign phase_next = phase + 2'd1;

    always_ff @(posedge clk or negedge nRESET) begin
        if (!nRESET) begin
            phase <= '0;
            cen_q <= 1'b0;
            cen_e <= 1'b0;
        end else begin
            cen_q <= 1'b0;
            cen_e <= 1'b0;
            if (cen8 && !hold) begin
                phase <= phase_next;
                cen_q <= phase_next == phase_q;
                cen_e <= phase_next == phase_e;  // End of bus cycle
            end
        end
    end

    // Stalls only stretch the cycle just before phase_e
    a_hold_before_e: assert property (
        @(posedge clk) disable iff (!nRESET)
        $rose(hold) |-> phase == phase_e - 2'd1
    ) else $error("cpu_phase_counter: hold raised outside the pre-phase_e window");

endmodule

//--- verilog/bus_wait_fsm.sv
/* Stretches the bus cycle before phase_e while SDRAM or video memory is pending.
   The check runs on the clk between cen8 ticks, so cen8 may be high at most every second clk. */
`timescale 1ns/10ps

module bus_wait_fsm import main_pkg::*; (
    input  logic       clk,
    input  logic       nRESET,
    input  logic       cen8,
    input  logic [1:0] phase,
    input  logic       mem_cs,
    input  logic       mem_ok,
    input  logic       dev_busy,
    output logic       hold
);

    wait_state_t state, state_next;
    logic        mem_pending;
    logic        at_pre_e;

    assign mem_pending = mem_cs && !mem_ok;
    assign at_pre_e    = phase == phase_e - 2'd1;   // Next tick would enter phase_e

    always_comb begin
        state_next = state;
        case (state)
            st_run: begin
                if (at_pre_e && !cen8) begin
                    if (mem_pending) begin
                        state_next = st_mem_wait;
                    end else if (dev_busy) begin
                        state_next = st_dev_wait;
                    end
                end
            end
            st_mem_wait: begin
                // Release on a tick, the counter moves on the following one
                if (cen8 && !mem_pending) begin
                    state_next = dev_busy ? st_dev_wait : st_run;
                end
            end
            st_dev_wait: begin
                if (cen8 && !dev_busy) begin
                    state_next = mem_pending ? st_mem_wait : st_run;
                end
            end
            default: state_next = st_run;
        endcase
    end

    always_ff @(posedge clk or negedge nRESET) begin
        if (!nRESET) begin
            state <= st_run;
            hold  <= 1'b0;
        end else begin
            state <= state_next;
            hold  <= state_next != st_run;
        end
    end

    // Pre-phase_e check needs a quiet clk between ticks
    a_cen8_spacing: assert property (
        @(posedge clk) disable iff (!nRESET)
        cen8 |=> !cen8
    ) else $error("bus_wait_fsm: cen8 high on two clk edges in a row");

endmodule

//--- verilog/main_board_top.sv
/* Main CPU glue of the banked board. The CPU itself sits outside and drives the bus ports.
   cen8 must not be high on two clk edges in a row, see bus_wait_fsm. */
`timescale 1ns/10ps

module main_board_top import main_pkg::*; (
    input  logic                  clk,
    input  logic                  nRESET,
    input  logic                  cen8,
    // CPU bus
    input  logic [addr_w-1:0]     cpu_addr,
    input  logic [data_w-1:0]     cpu_dout,
    input  logic                  cpu_rnw,
    input  logic                  cpu_vma,
    input  logic                  irq_ack,
    output logic [data_w-1:0]     cpu_din,
    output logic                  cen_q,
    output logic                  cen_e,
    output logic                  irq_n,
    // Video timing and cabinet
    input  logic                  lvbl,        // Low during vertical blank
    input  logic                  dip_pause,
    input  logic [1:0]            start_button,
    input  logic [1:0]            coin_input,
    input  logic                  service,
    input  logic [5:0]            joystick1,
    input  logic [5:0]            joystick2,
    input  logic [7:0]            dipsw_a,
    input  logic [7:0]            dipsw_b,
    // SDRAM
    output logic                  rom_cs,
    output logic [rom_addr_w-1:0] rom_addr,
    input  logic [data_w-1:0]     rom_data,
    input  logic                  rom_ok,
    output logic                  ram_cs,
    output logic [ram_addr_w-1:0] ram_addr,
    input  logic [data_w-1:0]     ram_data,
    input  logic                  ram_ok,
    // Video memories
    output logic                  scr_cs,
    input  logic [data_w-1:0]     scr_dout,
    input  logic                  scr_busy,
    output logic                  char_cs,
    input  logic [data_w-1:0]     char_dout,
    input  logic                  char_busy,
    output logic                  pal_cs,
    // Mapping PROM load
    input  logic [prom_aw-1:0]    prog_addr,
    input  logic [prom_w-1:0]     prom_din,
    input  logic [1:0]            prom_we,
    // I/O registers
    output logic                  flip,
    output logic                  sres_b,
    output logic [data_w-1:0]     snd_latch,
    output logic [pos_w-1:0]      scr_hpos,
    output logic [pos_w-1:0]      scr_vpos
);

    logic              io_cs;
    logic [7:0]        bank;
    logic [prom_w-1:0] map_hi, map_lo;
    logic [1:0]        phase;
    logic              hold;
    logic              mem_cs, mem_ok, dev_busy;

    assign mem_cs   = rom_cs | ram_cs;
    assign mem_ok   = rom_ok | ram_ok;
    assign dev_busy = scr_busy | char_busy;

    // Only six mapped bits reach the ROM
    assign rom_addr = {map_hi[1:0], map_lo, cpu_addr[11:0]};
    assign ram_addr = cpu_addr[ram_addr_w-1:0];

    addr_decode u_decode (
        .cpu_addr     ( cpu_addr     ),
        .cpu_rnw      ( cpu_rnw      ),
        .cpu_vma      ( cpu_vma      ),
        .rom_data     ( rom_data     ),
        .ram_data     ( ram_data     ),
        .scr_dout     ( scr_dout     ),
        .char_dout    ( char_dout    ),
        .start_button ( start_button ),
        .coin_input   ( coin_input   ),
        .service      ( service      ),
        .joystick1    ( joystick1    ),
        .joystick2    ( joystick2    ),
        .dipsw_a      ( dipsw_a      ),
        .dipsw_b      ( dipsw_b      ),
        .ram_cs       ( ram_cs       ),
        .scr_cs       ( scr_cs       ),
        .io_cs        ( io_cs        ),
        .rom_cs       ( rom_cs       ),
        .char_cs      ( char_cs      ),
        .pal_cs       ( pal_cs       ),
        .cpu_din      ( cpu_din      )
    );

    main_io_regs u_io (
        .clk       ( clk           ),
        .nRESET    ( nRESET        ),
        .cen_q     ( cen_q         ),
        .io_cs     ( io_cs         ),
        .cpu_rnw   ( cpu_rnw       ),
        .cpu_addr  ( cpu_addr[2:0] ),
        .cpu_dout  ( cpu_dout      ),
        .lvbl      ( lvbl          ),
        .dip_pause ( dip_pause     ),
        .irq_ack   ( irq_ack       ),
        .bank      ( bank          ),
        .flip      ( flip          ),
        .sres_b    ( sres_b        ),
        .scr_hpos  ( scr_hpos      ),
        .scr_vpos  ( scr_vpos      ),
        .snd_latch ( snd_latch     ),
        .irq_n     ( irq_n         )
    );

    bank_prom u_bank_hi (
        .clk     ( clk                         ),
        .rd_addr ( {bank[7:4], cpu_addr[15:12]} ),
        .wr_addr ( prog_addr                   ),
        .din     ( prom_din                    ),
        .we      ( prom_we[0]                  ),
        .q       ( map_hi                      )
    );

    bank_prom u_bank_lo (
        .clk     ( clk                         ),
        .rd_addr ( {bank[3:0], cpu_addr[15:12]} ),
        .wr_addr ( prog_addr                   ),
        .din     ( prom_din                    ),
        .we      ( prom_we[1]                  ),
        .q       ( map_lo                      )
    );

    cpu_phase_counter u_phase (
        .clk    ( clk    ),
        .nRESET ( nRESET ),
        .cen8   ( cen8   ),
        .hold   ( hold   ),
        .phase  ( phase  ),
        .cen_q  ( cen_q  ),
        .cen_e  ( cen_e  )
    );

    bus_wait_fsm u_wait (
        .clk      ( clk      ),
        .nRESET   ( nRESET   ),
        .cen8     ( cen8     ),
        .phase    ( phase    ),
        .mem_cs   ( mem_cs   ),
        .mem_ok   ( mem_ok   ),
        .dev_busy ( dev_busy ),
        .hold     ( hold     )
    );

endmodule

//--- verification/tb_main_board.sv
/* Random CPU bus testbench for main_board_top, with SDRAM and video memory responders.
   Every bus cycle is checked at cen_e against a reference model kept here. */
`timescale 1ns/10ps

module tb_main_board import main_pkg::*; ();

    localparam int n_cycles = 2000;
    localparam int wait_max = 200;   // clk periods allowed for one bus cycle

    logic                  clk = 1'b0;
    logic                  nRESET, cen8;
    logic [addr_w-1:0]     cpu_addr;
    logic [data_w-1:0]     cpu_dout, cpu_din;
    logic                  cpu_rnw, cpu_vma, irq_ack, cen_q, cen_e, irq_n;
    logic                  lvbl, dip_pause, service;
    logic [1:0]            start_button, coin_input;
    logic [5:0]            joystick1, joystick2;
    logic [7:0]            dipsw_a, dipsw_b;
    logic                  rom_cs, rom_ok, ram_cs, ram_ok;
    logic [rom_addr_w-1:0] rom_addr;
    logic [ram_addr_w-1:0] ram_addr;
    logic [data_w-1:0]     rom_data, ram_data, scr_dout, char_dout, snd_latch;
    logic                  scr_cs, char_cs, pal_cs, scr_busy, char_busy, flip, sres_b;
    logic [prom_aw-1:0]    prog_addr;
    logic [prom_w-1:0]     prom_din;
    logic [1:0]            prom_we;
    logic [pos_w-1:0]      scr_hpos, scr_vpos;

    // Reference model
    logic [prom_w-1:0]     prom_hi [prom_depth];
    logic [prom_w-1:0]     prom_lo [prom_depth];
    logic [addr_w-1:0]     cur_addr;
    logic [data_w-1:0]     cur_dout, m_bank, m_snd;
    logic                  cur_rnw, cur_vma, m_flip, m_sres_b;
    logic [pos_w-1:0]      m_hpos, m_vpos;
    logic                  m_irq_n = 1'b1;
    logic                  m_last_lvbl = 1'b0;
    logic                  cycle_done;
    int                    q_pulses;
    int                    mismatches = 0;
    int                    failures = 0;

    main_board_top main_board_top_inst (.*);

    always #2 clk = ~clk;

    task automatic check_byte(input string name, input logic [data_w-1:0] got, want);
        if (got !== want) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, want);
        if (got !== want) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_pos(input string name, input logic [pos_w-1:0] got, want);
        if (got !== want) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_rom_addr(input string name, input logic [rom_addr_w-1:0] got, want);
        if (got !== want) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_ram_addr(input string name, input logic [ram_addr_w-1:0] got, want);
        if (got !== want) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic finish_run();
        $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Selects as {ram, scr, io, rom, char, pal}
    function automatic logic [5:0] expect_selects(input logic [addr_w-1:0] a,
                                                  input logic rnw, input logic vma);
        logic [5:0] sel;
        sel = 6'b0;
        if (vma) begin
            case (a[15:12])
                4'h0, 4'h1: sel[5] = 1'b1;
                4'h2, 4'h3: sel[4] = 1'b1;
                4'h4:       sel[3] = a[3];
                default: begin
                    if (rnw) begin
                        sel[2] = 1'b1;
                    end else begin
                        sel[1] = a[15:12] == 4'h5;
                        sel[0] = a[15:12] == 4'h7;
                    end
                end
            endcase
        end
        return sel;
    endfunction

    function automatic logic [data_w-1:0] cabinet_byte(input logic [2:0] ofs);
        case (ofs)
            3'd0:    return {coin_input, service, 3'b111, start_button};
            3'd1:    return {2'b11, joystick1};
            3'd2:    return {2'b11, joystick2};
            3'd3:    return dipsw_a;
            3'd4:    return dipsw_b;
            default: return idle_byte;
        endcase
    endfunction

    // Counts cen_q pulses on the way to cen_e
    task automatic wait_bus_cycle(output logic done, output int n_q);
        int          n;
        wait_state_t st;
        n   = 0;
        n_q = 0;
        @(negedge clk);
        while (!cen_e && n < wait_max) begin
            if (cen_q) n_q++;
            @(negedge clk);
            n++;
        end
        done = cen_e;
        if (!done) begin
            st = main_board_top_inst.u_wait.state;
            failures++;
            $display("Error at %0t ns: no bus cycle completed, wait FSM in %s", $time, st.name());
        end
    endtask

    task automatic check_cycle();
        logic [5:0]        sel;
        logic [data_w-1:0] din_want;
        logic [prom_w-1:0] hi, lo;
        sel = expect_selects(cur_addr, cur_rnw, cur_vma);
        check_bit("ram_cs", ram_cs, sel[5]);
        check_bit("scr_cs", scr_cs, sel[4]);
        check_bit("rom_cs", rom_cs, sel[2]);
        check_bit("char_cs", char_cs, sel[1]);
        check_bit("pal_cs", pal_cs, sel[0]);
        // cen_e only after memory answered and video went idle
        if (sel[2]) check_bit("rom_ok", rom_ok, 1'b1);
        if (sel[5]) check_bit("ram_ok", ram_ok, 1'b1);
        check_bit("scr_busy", scr_busy, 1'b0);
        check_bit("char_busy", char_busy, 1'b0);
        if (cur_rnw) begin
            din_want = sel[2] ? rom_data : sel[5] ? ram_data : sel[4] ? scr_dout :
                       sel[1] ? char_dout : sel[3] ? cabinet_byte(cur_addr[2:0]) : idle_byte;
            check_byte("cpu_din", cpu_din, din_want);
        end else if (sel[3]) begin
            case (cur_addr[2:0])
                3'd0: m_bank = cur_dout;
                3'd1: begin
                    m_flip   = cur_dout[7];
                    m_sres_b = cur_dout[4];
                end
                3'd2: m_hpos[7:0] = cur_dout;
                3'd3: m_hpos[8]   = cur_dout[0];
                3'd4: m_vpos[7:0] = cur_dout;
                3'd5: m_vpos[8]   = cur_dout[0];
                3'd6: m_snd       = cur_dout;
                default: ;
            endcase
        end
        check_bit("flip", flip, m_flip);
        check_bit("sres_b", sres_b, m_sres_b);
        check_pos("scr_hpos", scr_hpos, m_hpos);
        check_pos("scr_vpos", scr_vpos, m_vpos);
        check_byte("snd_latch", snd_latch, m_snd);
        check_bit("irq_n", irq_n, m_irq_n);
        check_ram_addr("ram_addr", ram_addr, cur_addr[12:0]);
        hi = prom_hi[{m_bank[7:4], cur_addr[15:12]}];
        lo = prom_lo[{m_bank[3:0], cur_addr[15:12]}];
        check_rom_addr("rom_addr", rom_addr, {hi[1:0], lo, cur_addr[11:0]});
    endtask

    // New CPU cycle on the edge that ends cen_e
    task automatic drive_cpu();
        @(posedge clk);
        cur_addr = 16'($urandom);
        cur_rnw  = 1'($urandom);
        cur_vma  = ($urandom % 8) != 0;
        cur_dout = 8'($urandom);
        cpu_addr     <= cur_addr;
        cpu_rnw      <= cur_rnw;
        cpu_vma      <= cur_vma;
        cpu_dout     <= cur_dout;
        lvbl         <= ($urandom % 4 == 0) ? !lvbl : lvbl;
        dip_pause    <= ($urandom % 8 == 0);
        irq_ack      <= ($urandom % 6 == 0);
        start_button <= 2'($urandom);
        coin_input   <= 2'($urandom);
        service      <= 1'($urandom);
        joystick1    <= 6'($urandom);
        joystick2    <= 6'($urandom);
        dipsw_a      <= 8'($urandom);
        dipsw_b      <= 8'($urandom);
    endtask

    task automatic load_proms();
        logic [prom_w-1:0]  val;
        logic [prom_aw-1:0] a;
        for (int i = 0; i < prom_depth; i++) begin
            a = prom_aw'(i);
            for (int j = 0; j < 2; j++) begin
                @(posedge clk);
                val = prom_w'($urandom);
                prog_addr <= a;
                prom_din  <= val;
                prom_we   <= (j == 0) ? 2'b01 : 2'b10;   // Bit 0 loads the high PROM
                if (j == 0) prom_hi[a] = val;
                else prom_lo[a] = val;
            end
        end
        @(posedge clk);
        prom_we <= 2'b00;
    endtask

    // Interrupt flag mirror, sampled in the middle of each cen_q clk
    always @(negedge clk) begin
        if (nRESET && cen_q) begin
            if (irq_ack) begin
                m_irq_n = 1'b1;
            end else if (m_last_lvbl && !lvbl && !dip_pause) begin
                m_irq_n = 1'b0;
            end
            m_last_lvbl = lvbl;
        end
    end

    // SDRAM and video memory side
    initial begin : responder
        int mem_wait;
        int scr_left;
        int char_left;
        mem_wait  = 0;
        scr_left  = 0;
        char_left = 0;
        cen8      <= 1'b0;
        rom_ok    <= 1'b0;
        ram_ok    <= 1'b0;
        rom_data  <= '0;
        ram_data  <= '0;
        scr_dout  <= '0;
        char_dout <= '0;
        scr_busy  <= 1'b0;
        char_busy <= 1'b0;
        forever begin
            @(posedge clk);
            cen8 <= !cen8;
            if (cen_e) begin
                mem_wait  = $urandom % 24;
                scr_left  = ($urandom % 3 == 0) ? $urandom % 16 : 0;
                char_left = ($urandom % 3 == 0) ? $urandom % 16 : 0;
                rom_ok    <= 1'b0;
                ram_ok    <= 1'b0;
                rom_data  <= 8'($urandom);
                ram_data  <= 8'($urandom);
                scr_dout  <= 8'($urandom);
                char_dout <= 8'($urandom);
            end else begin
                if (mem_wait > 0) begin
                    mem_wait--;
                end else begin
                    rom_ok <= rom_ok | rom_cs;   // Ok stays up until the cycle ends
                    ram_ok <= ram_ok | ram_cs;
                end
                if (scr_left > 0) scr_left--;
                if (char_left > 0) char_left--;
            end
            scr_busy  <= scr_left > 0;
            char_busy <= char_left > 0;
        end
    end

    initial begin
        void'($urandom(17591));
        cur_addr = '0;
        cur_rnw  = 1'b1;
        cur_vma  = 1'b0;
        cur_dout = '0;
        m_bank   = '0;
        m_snd    = '0;
        m_flip   = 1'b0;
        m_sres_b = 1'b1;
        m_hpos   = '0;
        m_vpos   = '0;
        nRESET       <= 1'b0;
        cpu_addr     <= cur_addr;
        cpu_dout     <= cur_dout;
        cpu_rnw      <= cur_rnw;
        cpu_vma      <= cur_vma;
        irq_ack      <= 1'b0;
        lvbl         <= 1'b1;
        dip_pause    <= 1'b0;
        start_button <= '0;
        coin_input   <= '0;
        service      <= 1'b0;
        joystick1    <= '0;
        joystick2    <= '0;
        dipsw_a      <= '0;
        dipsw_b      <= '0;
        prog_addr    <= '0;
        prom_din     <= '0;
        prom_we      <= 2'b00;
        repeat (2) @(posedge clk);
        nRESET <= 1'b1;
        @(negedge clk);
        check_bit("cen_q", cen_q, 1'b0);
        check_bit("cen_e", cen_e, 1'b0);
        check_bit("irq_n", irq_n, 1'b1);
        check_bit("sres_b", sres_b, 1'b1);
        check_bit("flip", flip, 1'b0);
        check_pos("scr_hpos", scr_hpos, '0);
        check_pos("scr_vpos", scr_vpos, '0);
        check_byte("snd_latch", snd_latch, '0);
        load_proms();
        for (int c = 0; c < n_cycles; c++) begin
            wait_bus_cycle(cycle_done, q_pulses);
            if (!cycle_done) break;
            // The first cycle may have started before the loop
            if (c > 0 && q_pulses != 1) begin
                failures++;
                $display("Error at %0t ns: %0d cen_q pulses in one bus cycle instead of one",
                         $time, q_pulses);
            end
            check_cycle();
            drive_cpu();
        end
        finish_run();
    end

endmodule

//--- list.f
verilog/main_pkg.sv
verilog/addr_decode.sv
verilog/main_io_regs.sv
verilog/bank_prom.sv
verilog/cpu_phase_counter.sv
verilog/bus_wait_fsm.sv
verilog/main_board_top.sv
verification/tb_main_board.sv

//--- run_sim.sh
#!/bin/sh
# Builds the main board testbench with Verilator and runs it, output in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_main_board \
    -o sim_main > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

# A simulator error exit counts as a failed run
./obj_dir/sim_main > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
